//--- Makefile
# Verilator build and run of the command bridge testbench.
# Variables can be overridden on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= up_bridge_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
+incdir+hw
hw/up_bridge_pkg.sv
hw/byte_lane_if.sv
hw/up_link_fsm.sv
hw/byte_lane.sv
hw/command_unit.sv
hw/up_bridge_top.sv
testbench/up_bridge_asserts.sv
testbench/up_bridge_tb.sv

//--- hw/byte_lane.sv
/*
  Word shift register and byte counter between the host port and the
  command unit. Bytes shift in and out most significant first.
*/
`timescale 1ns/1ns
`include "up_bridge_config.svh"

module byte_lane
  import up_bridge_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`UP_BYTE_W-1:0] data_in,
  input  cmd_word_t             result,
  output logic [`UP_BYTE_W-1:0] data_out,
  output cmd_word_t             word,
  byte_lane_if.lane             ctl
);

  localparam int CNT_W = $clog2(`UP_BYTES + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset)
      count <= '0;
    else if (ctl.start_rx || ctl.start_tx)
      count <= CNT_W'(`UP_BYTES);
    else if (ctl.capture || ctl.advance)
      count <= count - CNT_W'(1);
  end

  // Word register, byte view
  always_ff @(posedge clk) begin
    if (ctl.start_rx) begin
      word <= '0;
    end else if (ctl.start_tx) begin
      word <= result;
    end else if (ctl.capture) begin
      word.bytes[`UP_BYTES-1:1] <= word.bytes[`UP_BYTES-2:0];
      word.bytes[0]             <= data_in;    // New byte enters at the bottom
    end else if (ctl.advance) begin
      word.bytes[`UP_BYTES-1:1] <= word.bytes[`UP_BYTES-2:0];
      word.bytes[0]             <= '0;
    end
  end

  assign data_out = word.bytes[`UP_BYTES-1];  // Top byte leaves first
  assign ctl.done = (count == '0);

endmodule

//--- hw/byte_lane_if.sv
/*
  Control bundle from the link FSM to the byte lane.
  The FSM issues one-cycle commands and watches the lane's done flag.
*/
`timescale 1ns/1ns

interface byte_lane_if;
  logic start_rx;  // Clear word, load count
  logic capture;   // Shift in one host byte
  logic start_tx;  // Load result word, load count
  logic advance;   // Shift out one byte
  logic done;      // Count at zero

  modport fsm (output start_rx, capture, start_tx, advance, input done);
  modport lane (input start_rx, capture, start_tx, advance, output done);
endinterface

//--- hw/command_unit.sv
/*
  Executes one command word against a 32-bit accumulator.
  On execute the opcode view is decoded and the result word is registered:
  the new accumulator for known opcodes, the raw word for anything else.
*/
`timescale 1ns/1ns
`include "up_bridge_config.svh"

module command_unit
  import up_bridge_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      execute,
  input  cmd_word_t word,
  output cmd_word_t result
);

  localparam int ARG_W = `UP_WORD_W - `UP_BYTE_W;

  logic [`UP_WORD_W-1:0] acc;
  logic [`UP_WORD_W-1:0] acc_next;
  logic [`UP_WORD_W-1:0] arg_ext;
  logic                  is_echo;

  always_comb begin
    arg_ext  = {{(`UP_WORD_W-ARG_W){1'b0}}, word.cmd.arg};
    acc_next = acc;
    is_echo  = 1'b0;
    case (word.cmd.opcode)
      OP_LOAD:  acc_next = arg_ext;
      OP_ADD:   acc_next = acc + arg_ext;
      OP_READ:  acc_next = acc;
      OP_CLEAR: acc_next = '0;
      default:  is_echo = 1'b1;           // Unknown opcode
    endcase
  end

  // Kept across soft_reset
  always_ff @(posedge clk or negedge reset) begin
    if (!reset)
      acc <= '0;
    else if (execute)
      acc <= acc_next;
  end

  always_ff @(posedge clk) begin
    if (execute)
      result <= is_echo ? word : cmd_word_t'(acc_next);
  end

endmodule

//--- hw/up_bridge_config.svh
/*
  Sizing constants for the microprocessor command bridge.
  Include in any file that needs the word, byte or byte count widths.
*/
`ifndef UP_BRIDGE_CONFIG_SVH
`define UP_BRIDGE_CONFIG_SVH

`define UP_WORD_W 32  // Command and result word
`define UP_BYTE_W 8   // Host data bus
`define UP_BYTES  4   // Bytes per word

`endif

//--- hw/up_bridge_pkg.sv
/*
  Types shared by the bridge: the command opcodes and the command word,
  which is seen as raw bus bytes or as an opcode with its argument.
*/
`include "up_bridge_config.svh"

package up_bridge_pkg;

  // Unlisted codes are echoed back unchanged
  typedef enum logic [`UP_BYTE_W-1:0] {
    OP_LOAD  = 8'd1,
    OP_ADD   = 8'd2,
    OP_READ  = 8'd3,
    OP_CLEAR = 8'd4
  } opcode_t;

  typedef struct packed {
    opcode_t                          opcode;  // Top byte, first on the bus
    logic [`UP_WORD_W-`UP_BYTE_W-1:0] arg;
  } cmd_fields_t;

  // ------------------------------------------------------------------------
  // Byte view for the lane, field view for the command unit
  // ------------------------------------------------------------------------
  typedef union packed {
    logic [`UP_BYTES-1:0][`UP_BYTE_W-1:0] bytes;  // Index 3 goes first
    cmd_fields_t                          cmd;
  } cmd_word_t;

endpackage

//--- hw/up_bridge_top.sv
/*
  Top level of the byte-wide command bridge. Connects the link FSM,
  the byte lane and the command unit; the host sees plain ports only.
*/
`timescale 1ns/1ns
`include "up_bridge_config.svh"

module up_bridge_top
  import up_bridge_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic                  soft_reset,
  input  logic                  strobe,
  input  logic [`UP_BYTE_W-1:0] data_in,
  output logic [`UP_BYTE_W-1:0] data_out,
  output logic                  rw,
  output logic                  byte_ack,
  output logic                  ack
);

  byte_lane_if lane_bus ();

  logic      execute;
  cmd_word_t word;
  cmd_word_t result;

  up_link_fsm up_link_fsm_i (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .soft_reset (soft_reset),
    .strobe     (strobe),
    .rw         (rw),
    .byte_ack   (byte_ack),
    .ack        (ack),
    .execute    (execute),
    .lane       (lane_bus.fsm)
  );

  byte_lane byte_lane_i (
    .clk      (clk),
    .reset    (reset),
    .data_in  (data_in),
    .result   (result),
    .data_out (data_out),
    .word     (word),
    .ctl      (lane_bus.lane)
  );

  command_unit command_unit_i (
    .clk     (clk),
    .reset   (reset),
    .execute (execute),
    .word    (word),
    .result  (result)
  );

endmodule

//--- hw/up_link_fsm.sv
/*
  Moore FSM that runs one bridge transaction: four byte reads from the
  host, one execute pulse, four byte writes back and a closing ack.
  Each byte uses the strobe/byte_ack handshake; soft_reset aborts to idle.
*/
`timescale 1ns/1ns

module up_link_fsm (
  input  logic      clk,
  input  logic      reset,
  input  logic      start,
  input  logic      soft_reset,
  input  logic      strobe,
  output logic      rw,
  output logic      byte_ack,
  output logic      ack,
  output logic      execute,
  byte_lane_if.fsm  lane
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_ARM,
    S_R0, S_R1, S_R2, S_R3,              // Read one byte
    S_EXEC,
    S_TX_LOAD,
    S_W0, S_W1, S_W2, S_W3, S_W4,        // Write one byte
    S_ACK,
    S_HOLD
  } state_t;

  state_t state, next_state;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset)
      state <= S_IDLE;
    else
      state <= next_state;
  end

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------
  always_comb begin : set_next_state
    next_state = state;
    case (state)
      S_IDLE:    next_state = start ? S_ARM : S_IDLE;
      S_ARM:     next_state = S_R0;

      S_R0:      next_state = strobe ? S_R1 : S_R0;  // Host byte ready
      S_R1:      next_state = S_R2;
      S_R2:      next_state = S_R3;
      S_R3: begin
        if (!strobe)
          next_state = lane.done ? S_EXEC : S_R0;
      end

      S_EXEC:    next_state = S_TX_LOAD;
      S_TX_LOAD: next_state = S_W0;

      S_W0:      next_state = S_W1;
      S_W1:      next_state = strobe ? S_W2 : S_W1;  // Host took the byte
      S_W2:      next_state = S_W3;
      S_W3: begin
        if (!strobe)
          next_state = lane.done ? S_W4 : S_W0;
      end
      S_W4:      next_state = S_ACK;

      S_ACK:     next_state = S_HOLD;
      S_HOLD:    next_state = start ? S_HOLD : S_IDLE;
      default:   next_state = S_IDLE;
    endcase

    // Abort from anywhere
    if (soft_reset)
      next_state = S_IDLE;
  end : set_next_state

  // --------------------------------------------------------------------------
  // Outputs, decoded from state only
  // --------------------------------------------------------------------------
  always_comb begin : set_outputs
    rw            = 1'b0;
    byte_ack      = 1'b0;
    ack           = 1'b0;
    execute       = 1'b0;
    lane.start_rx = 1'b0;
    lane.capture  = 1'b0;
    lane.start_tx = 1'b0;
    lane.advance  = 1'b0;
    case (state)
      S_ARM:     lane.start_rx = 1'b1;
      S_R1:      byte_ack = 1'b1;
      S_R2:      lane.capture = 1'b1;       // data_in still held by host
      S_EXEC:    execute = 1'b1;
      S_TX_LOAD: lane.start_tx = 1'b1;
      S_W0: begin
        rw       = 1'b1;
        byte_ack = 1'b1;                    // Byte valid on data_out
      end
      S_W1, S_W3: rw = 1'b1;
      S_W2: begin
        rw           = 1'b1;
        lane.advance = 1'b1;
      end
      S_ACK:     ack = 1'b1;
      default: ;
    endcase
  end : set_outputs

endmodule

//--- testbench/up_bridge_asserts.sv
/*
  Concurrent checks on the link handshake, bound to the link FSM
  from the testbench.
*/
`timescale 1ns/1ns

module up_bridge_asserts (
  input logic clk,
  input logic reset,
  input logic start,
  input logic soft_reset,
  input logic rw,
  input logic byte_ack,
  input logic ack,
  input logic execute
);

  logic in_write;   // From execute until ack
  logic after_ack;  // From ack until start falls

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      in_write  <= 1'b0;
      after_ack <= 1'b0;
    end else begin
      if (ack || soft_reset)
        in_write <= 1'b0;
      else if (execute)
        in_write <= 1'b1;
      if (ack)
        after_ack <= 1'b1;
      else if (!start || soft_reset)
        after_ack <= 1'b0;
    end
  end

  byte_ack_single: assert property (@(posedge clk) disable iff (!reset) byte_ack |=> !byte_ack)
    else $error("byte_ack high for two cycles in a row");

  quiet_after_ack: assert property (@(posedge clk) disable iff (!reset) after_ack |-> !byte_ack)
    else $error("byte_ack after ack before start fell");

  rw_in_write: assert property (@(posedge clk) disable iff (!reset) rw |-> in_write)
    else $error("rw high outside the write phase");

endmodule

//--- testbench/up_bridge_tb.sv
/*
  Testbench for the command bridge. A host model sends random commands
  over the strobe/byte_ack handshake and compares each result with a
  model accumulator. One line per test, then the counts.
*/
`timescale 1ns/1ns

module up_bridge_tb;
  localparam int TIMEOUT = 60;  // Cycles per wait

  logic       clk, reset, start, soft_reset, strobe;
  logic [7:0] data_in, data_out;
  logic       rw, byte_ack, ack;
  logic [31:0] model_acc;
  int          checks, errors, ack_count;

  up_bridge_top up_bridge_top_i (.*);

  bind up_link_fsm up_bridge_asserts link_asserts_i (
    .clk(clk), .reset(reset), .start(start), .soft_reset(soft_reset),
    .rw(rw), .byte_ack(byte_ack), .ack(ack), .execute(execute)
  );

  always #20 clk = ~clk;

  always @(negedge clk) begin
    if (ack)
      ack_count++;
  end

  // --------------------------------------------------------------------------
  // Host model
  // --------------------------------------------------------------------------
  task automatic step();
    @(posedge clk);
    #5;  // Drive and sample point
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic wait_pulse(input bit on_ack, input string what, output bit ok);
    int n;
    n = 0;
    do begin
      step();
      n++;
    end while (!(on_ack ? ack : byte_ack) && n < TIMEOUT);
    ok = on_ack ? ack : byte_ack;
    if (!ok) begin
      errors++;
      $display("Timeout at %0t ns: the bridge gave no %s in %0d cycles", $time, what, TIMEOUT);
    end
  endtask

  task automatic send_byte(input logic [7:0] b, input bit last, output bit ok);
    data_in = b;
    strobe  = 1'b1;
    wait_pulse(1'b0, "byte_ack for a read byte", ok);
    if (ok)
      check("rw at read byte_ack", 32'(rw), 32'd0);
    strobe = 1'b0;  // data_in held until the capture
    if (ok && !last)
      repeat (3 + $urandom_range(1, 0)) step();
  endtask

  task automatic recv_byte(output logic [7:0] b, output bit ok);
    wait_pulse(1'b0, "byte_ack for a write byte", ok);
    b = data_out;
    if (ok) begin
      check("rw at write byte_ack", 32'(rw), 32'd1);
      strobe = 1'b1;
      repeat (2 + $urandom_range(1, 0)) step();
      strobe = 1'b0;
    end
  endtask

  function automatic logic [31:0] predict(input logic [31:0] w);
    logic [31:0] arg;
    arg = {8'h00, w[23:0]};
    case (w[31:24])
      8'd1: model_acc = arg;
      8'd2: model_acc = model_acc + arg;
      8'd3: ;
      8'd4: model_acc = '0;
      default: return w;  // Echo keeps the accumulator
    endcase
    return model_acc;
  endfunction

  function automatic logic [31:0] rand_cmd(input bit known);
    logic [7:0] op;
    op = known ? 8'($urandom_range(4, 1)) : 8'($urandom_range(255, 5));
    return {op, 24'($urandom)};
  endfunction

  task automatic run_command(input logic [31:0] w, input int hold, output bit ok);
    logic [31:0] got;
    logic [31:0] exp;
    logic [7:0]  b;
    int          acks;
    got   = '0;
    acks  = ack_count;
    exp   = predict(w);
    ok    = 1'b1;
    start = 1'b1;
    step();
    for (int i = 3; i >= 0 && ok; i--)
      send_byte(w[i*8 +: 8], i == 0, ok);
    for (int i = 0; i < 4 && ok; i++) begin
      recv_byte(b, ok);
      got = {got[23:0], b};  // MSB first
    end
    if (ok)
      wait_pulse(1'b1, "ack", ok);
    if (ok) begin
      check($sformatf("result for command %h", w), got, exp);
      strobe = 1'b1;  // A restarted link would take this byte
      repeat (hold) begin
        step();
        check("byte_ack and ack with start held", 32'({byte_ack, ack}), 32'd0);
      end
    end
    start = 1'b0;
    strobe = 1'b0;
    soft_reset = !ok;  // Clears a stuck link
    repeat (2) step();
    soft_reset = 1'b0;
    if (ok)
      check("ack pulses per transaction", ack_count - acks, 32'd1);
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (errors == errs_before)
      $display("Test %s: ok", name);
    else
      $display("Test %s: %0d errors", name, errors - errs_before);
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    int          e;
    int          acks;
    bit          ok;
    logic [31:0] w;
    clk        = 1'b0;
    reset      = 1'b0;
    start      = 1'b0;
    soft_reset = 1'b0;
    strobe     = 1'b0;
    data_in    = '0;
    checks     = 0;
    errors     = 0;
    ack_count  = 0;
    model_acc  = '0;
    void'($urandom(7510));
    repeat (5) @(posedge clk);
    #5 reset = 1'b1;

    e = errors;
    check("rw, byte_ack, ack after reset", 32'({rw, byte_ack, ack}), 32'd0);
    end_test("reset state", e);

    e = errors;
    for (int n = 0; n < 16; n++)
      run_command(rand_cmd(1'b1), 0, ok);
    end_test("command results", e);

    e = errors;
    for (int n = 0; n < 8; n++)
      run_command(rand_cmd(1'b0), 0, ok);
    run_command(32'h0300_0000, 0, ok);  // READ shows the kept accumulator
    end_test("echo", e);

    e = errors;
    for (int n = 0; n < 4; n++)
      run_command(rand_cmd(1'b1), 4 + $urandom_range(4, 0), ok);
    end_test("write phase handshake", e);

    e = errors;
    w     = rand_cmd(1'b1);
    acks  = ack_count;
    start = 1'b1;
    step();
    send_byte(w[31:24], 1'b0, ok);
    if (ok)
      send_byte(w[23:16], 1'b0, ok);
    start      = 1'b0;
    soft_reset = 1'b1;  // Abort mid read phase
    step();
    soft_reset = 1'b0;
    strobe     = 1'b1;  // Only a link that missed the abort takes it
    repeat (10) begin
      step();
      check("rw, byte_ack, ack after soft_reset", 32'({rw, byte_ack, ack}), 32'd0);
    end
    strobe = 1'b0;
    check("ack pulses after abort", ack_count - acks, 32'd0);
    run_command(32'h0300_0000, 0, ok);
    run_command(rand_cmd(1'b1), 0, ok);
    end_test("soft reset", e);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule
